//--- tb.f
design/udp_tx_pkg.sv
design/frame_desc_if.sv
design/udp_header_builder.sv
design/payload_fifo.sv
design/frame_serializer.sv
design/udp_tx_top.sv
tests/udp_tx_asserts.sv
tests/udp_tx_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the UDP transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module udp_tx_tb -f tb.f -o udp_tx_sim

./obj_dir/udp_tx_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

//--- tests/udp_tx_tb.sv
module udp_tx_tb;
    import udp_tx_pkg::*;

    // One row of the stimulus table
    typedef struct {
        int        n_write;
        bit        do_flush;
        bit        expect_full;
        mac_addr_t dest_mac;
        mac_addr_t src_mac;
        ip_addr_t  src_ip;
        ip_addr_t  dest_ip;
        port_t     src_port;
        port_t     dest_port;
        int        n_frames;
        int        payload[4];
        int        padding[4];
    } case_t;

    // What one frame on the line should carry
    typedef struct {
        int          payload;
        int          padding;
        mac_header_t mac;
        ip_header_t  ip;
        udp_header_t udp;
    } frame_exp_t;

    logic      clk;
    logic      reset;
    logic      wr_en;
    logic      flush;
    nibble_t   wr_data;
    logic      wr_full;
    mac_addr_t src_mac;
    mac_addr_t dest_mac;
    ip_addr_t  src_ip;
    ip_addr_t  dest_ip;
    port_t     src_port;
    port_t     dest_port;
    logic      tx_en;
    nibble_t   tx_d;
    logic      mac_busy;

    case_t       cases[6];
    frame_exp_t  exp_q[$];
    // Accepted payload nibbles in write order
    nibble_t     ref_q[$];
    nibble_t     cap[$];
    nibble_t     exp_stream[$];
    int          frames_seen;
    int          low_cycles;
    bit          in_frame;
    logic [31:0] rng_state;

    udp_tx_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .flush     (flush),
        .wr_data   (wr_data),
        .wr_full   (wr_full),
        .src_mac   (src_mac),
        .dest_mac  (dest_mac),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .tx_en     (tx_en),
        .tx_d      (tx_d),
        .mac_busy  (mac_busy)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Ones' complement sum of the ten header words
    function automatic logic [15:0] ip_checksum(input ip_header_t hdr);
        logic [31:0] sum;
        sum = 0;
        for (int w = 0; w < 10; w++) begin
            sum = sum + 32'(hdr[16 * w +: 16]);
        end
        while (sum[31:16] != 0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    function automatic ip_header_t make_ip(input int payload, input ip_addr_t sip,
                                           input ip_addr_t dip);
        ip_header_t hdr;
        hdr = {8'h45, 8'h00, 16'(28 + payload / 2), 16'h0000, 16'h0000,
            IP_TTL, IP_PROTOCOL_UDP, 16'h0000, sip, dip};
        hdr[79:64] = ip_checksum(hdr);
        return hdr;
    endfunction

    // Top byte first and low nibble of each byte first
    function automatic void add_bytes(input logic [159:0] vec, input int nbytes);
        logic [7:0] b;
        for (int i = 0; i < nbytes; i++) begin
            b = vec[8 * (nbytes - 1 - i) +: 8];
            exp_stream.push_back(b[3:0]);
            exp_stream.push_back(b[7:4]);
        end
    endfunction

    function automatic logic [7:0] byte_at(input int idx);
        return {cap[16 + 2 * idx + 1], cap[16 + 2 * idx]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [159:0] exp,
                                   input logic [159:0] got);
        $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_nibble(input string name, input nibble_t exp, input nibble_t got);
        if (exp !== got) report_mismatch(name, 160'(exp), 160'(got));
    endtask

    task automatic check_mac(input string name, input mac_addr_t exp, input mac_addr_t got);
        if (exp !== got) report_mismatch(name, 160'(exp), 160'(got));
    endtask

    task automatic check_ip(input string name, input ip_addr_t exp, input ip_addr_t got);
        if (exp !== got) report_mismatch(name, 160'(exp), 160'(got));
    endtask

    task automatic check_port(input string name, input port_t exp, input port_t got);
        if (exp !== got) report_mismatch(name, 160'(exp), 160'(got));
    endtask

    task automatic check_count(input string name, input nibble_count_t exp,
                               input nibble_count_t got);
        if (exp !== got) report_mismatch(name, 160'(exp), 160'(got));
    endtask

    task automatic check_crc(input string name, input crc_t exp, input crc_t got);
        if (exp !== got) report_mismatch(name, 160'(exp), 160'(got));
    endtask

    // Rebuild the whole expected frame and compare it with the capture
    task automatic analyze_frame();
        frame_exp_t  e;
        crc_t        crc;
        crc_t        got_crc;
        nibble_t     n;
        mac_header_t got_mac;
        ip_header_t  got_ip;
        udp_header_t got_udp;
        int          base;
        if (exp_q.size() == 0) abort_run("A frame appeared that no case expected");
        e = exp_q.pop_front();
        exp_stream = {};
        for (int i = 0; i < 15; i++) exp_stream.push_back(4'h5);
        exp_stream.push_back(4'hD);
        add_bytes(160'(e.mac), 14);
        add_bytes(160'(e.ip), 20);
        add_bytes(160'(e.udp), 8);
        for (int i = 0; i < e.payload; i++) begin
            if (ref_q.size() == 0) abort_run("Frame carries more payload than was written");
            exp_stream.push_back(ref_q.pop_front());
        end
        for (int i = 0; i < e.padding; i++) exp_stream.push_back(4'h0);
        // CRC over everything after the SFD
        crc = '1;
        for (int i = 16; i < exp_stream.size(); i++) begin
            crc = crc_nibble_update(crc, exp_stream[i]);
        end
        // Inverted and bit reversed FCS nibbles from the top of the CRC down
        for (int k = 7; k >= 0; k--) begin
            n = ~crc[4 * k +: 4];
            exp_stream.push_back({n[0], n[1], n[2], n[3]});
        end
        check_count("frame_nibbles", nibble_count_t'(exp_stream.size()),
            nibble_count_t'(cap.size()));
        for (int j = 0; j < 14; j++) got_mac[8 * (13 - j) +: 8] = byte_at(j);
        for (int j = 0; j < 20; j++) got_ip[8 * (19 - j) +: 8] = byte_at(14 + j);
        for (int j = 0; j < 8; j++) got_udp[8 * (7 - j) +: 8] = byte_at(34 + j);
        check_mac("dest_mac", e.mac[111:64], got_mac[111:64]);
        check_mac("src_mac", e.mac[63:16], got_mac[63:16]);
        check_ip("src_ip", e.ip[63:32], got_ip[63:32]);
        check_ip("dest_ip", e.ip[31:0], got_ip[31:0]);
        check_port("src_port", e.udp[63:48], got_udp[63:48]);
        check_port("dest_port", e.udp[47:32], got_udp[47:32]);
        base = cap.size() - 8;
        for (int i = 0; i < 8; i++) begin
            n = ~cap[base + i];
            got_crc[4 * (7 - i) +: 4] = {n[0], n[1], n[2], n[3]};
        end
        check_crc("fcs", crc, got_crc);
        for (int i = 0; i < cap.size(); i++) begin
            check_nibble($sformatf("tx_d[%0d]", i), exp_stream[i], cap[i]);
        end
    endtask

    // Line monitor sampled on the falling edge
    always @(negedge clk) begin
        if (!reset && tx_en === 1'b1) begin
            if (!in_frame) begin
                if (frames_seen > 0 && low_cycles < GAP_NIBBLES) begin
                    abort_run("Interframe gap shorter than GAP_NIBBLES");
                end
                cap = {};
                in_frame = 1'b1;
            end
            cap.push_back(tx_d);
        end else begin
            if (in_frame) begin
                analyze_frame();
                frames_seen++;
                in_frame = 1'b0;
                low_cycles = 0;
            end
            low_cycles++;
        end
    end

    task automatic run_case(input case_t tc);
        frame_exp_t e;
        int         target;
        int         dropped;
        int         limit;
        bit         full_seen;
        @(posedge clk);
        dest_mac  <= tc.dest_mac;
        src_mac   <= tc.src_mac;
        src_ip    <= tc.src_ip;
        dest_ip   <= tc.dest_ip;
        src_port  <= tc.src_port;
        dest_port <= tc.dest_port;
        for (int f = 0; f < tc.n_frames; f++) begin
            e.payload = tc.payload[f];
            e.padding = tc.padding[f];
            e.mac     = {tc.dest_mac, tc.src_mac, 16'h0800};
            e.ip      = make_ip(tc.payload[f], tc.src_ip, tc.dest_ip);
            e.udp     = {tc.src_port, tc.dest_port, 16'(8 + tc.payload[f] / 2), 16'h0000};
            exp_q.push_back(e);
        end
        target    = frames_seen + tc.n_frames;
        full_seen = 1'b0;
        dropped   = 0;
        for (int i = 0; i < tc.n_write; i++) begin
            rng_state = xorshift32(rng_state);
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_data <= rng_state[3:0];
            // Full here means the coming edge drops this write
            @(negedge clk);
            if (wr_full) begin
                full_seen = 1'b1;
                dropped++;
            end else begin
                ref_q.push_back(rng_state[3:0]);
            end
        end
        @(posedge clk);
        wr_en <= 1'b0;
        if (tc.do_flush) begin
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
        end
        limit = 0;
        while (frames_seen < target) begin
            @(posedge clk);
            limit++;
            if (limit > 5000) abort_run("Timed out waiting for a frame on tx_en");
        end
        limit = 0;
        while (mac_busy !== 1'b0) begin
            @(posedge clk);
            limit++;
            if (limit > 200) abort_run("mac_busy did not fall after the frame");
        end
        // A flush below one word must leave the line quiet
        if (tc.n_frames == 0) begin
            for (int i = 0; i < 100; i++) begin
                @(posedge clk);
                if (mac_busy || frames_seen != target) abort_run("Short flush started a frame");
            end
        end
        if (tc.expect_full && !full_seen) abort_run("wr_full never rose at full depth");
        if (!tc.expect_full && dropped != 0) abort_run("Writes dropped without a full buffer");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        wr_en       = 1'b0;
        flush       = 1'b0;
        wr_data     = '0;
        src_mac     = '0;
        dest_mac    = '0;
        src_ip      = '0;
        dest_ip     = '0;
        src_port    = '0;
        dest_port   = '0;
        frames_seen = 0;
        low_cycles  = 0;
        in_frame    = 1'b0;
        rng_state   = 32'd27250;
        // Exact minimum and then 200 buffered behind a running frame
        cases[0] = '{64, 1'b0, 1'b0, 48'h0010_A4_7B_EA_80, 48'h0002_B3_C4_D5_E6,
            32'hC0A8_0001, 32'hC0A8_0002, 16'd1234, 16'd5678, 1,
            '{64, 0, 0, 0}, '{0, 0, 0, 0}};
        cases[1] = '{264, 1'b0, 1'b0, 48'hFFFF_FFFF_FFFF, 48'h1234_5678_9ABC,
            32'h0A00_0001, 32'h0A00_00FE, 16'd53, 16'd49152, 3,
            '{64, 128, 72, 0}, '{0, 0, 0, 0}};
        // Flush with 20 and then with the 4 left over
        cases[2] = '{20, 1'b1, 1'b0, 48'hAABB_CCDD_EEFF, 48'h0011_2233_4455,
            32'hAC10_FE01, 32'hE000_00FB, 16'd5353, 16'd5353, 1,
            '{16, 0, 0, 0}, '{20, 0, 0, 0}};
        cases[3] = '{0, 1'b1, 1'b0, 48'h0, 48'h0, 32'h0, 32'h0, 16'd0, 16'd0, 0,
            '{0, 0, 0, 0}, '{0, 0, 0, 0}};
        cases[4] = '{60, 1'b0, 1'b0, 48'h0200_0000_0001, 48'h0200_0000_0002,
            32'h7F00_0001, 32'h7F00_0001, 16'hFFFF, 16'h0001, 1,
            '{64, 0, 0, 0}, '{0, 0, 0, 0}};
        // Long burst that fills the buffer during a frame
        cases[5] = '{600, 1'b0, 1'b1, 48'h5E00_0001_0203, 48'h00E0_4C68_0001,
            32'h8080_8080, 32'h0101_0101, 16'd7, 16'd9, 4,
            '{64, 128, 128, 128}, '{0, 0, 0, 0}};
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int c = 0; c < 6; c++) begin
            run_case(cases[c]);
        end
        if (ref_q.size() != 0 || exp_q.size() != 0) begin
            $display("Payload left over or expected frames missing");
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- tests/udp_tx_asserts.sv
module udp_tx_asserts (
    input logic                      clk,
    input logic                      reset,
    input logic                      tx_en,
    input udp_tx_pkg::nibble_t       tx_d,
    input logic                      mac_busy,
    input logic                      wr_full,
    input logic                      rd_en,
    input udp_tx_pkg::nibble_count_t fill
);

    // Idle line carries zero nibbles
    idle_line_zero: assert property (@(posedge clk) disable iff (reset)
        !tx_en |-> (tx_d == '0))
        else $error("tx_d is nonzero while tx_en is low");

    // Every frame lies inside the busy level
    busy_covers_tx: assert property (@(posedge clk) disable iff (reset)
        tx_en |-> mac_busy)
        else $error("tx_en is high while mac_busy is low");

    // A pop always frees a slot
    full_clears_on_pop: assert property (@(posedge clk) disable iff (reset)
        (rd_en && fill != '0) |=> !wr_full)
        else $error("wr_full still set one cycle after a pop");

endmodule

bind udp_tx_top udp_tx_asserts i_asserts (
    .clk      (clk),
    .reset    (reset),
    .tx_en    (tx_en),
    .tx_d     (tx_d),
    .mac_busy (mac_busy),
    .wr_full  (wr_full),
    .rd_en    (fifo_rd_en),
    .fill     (fifo_count)
);

//--- design/udp_tx_top.sv
module udp_tx_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic                  flush,
    input  udp_tx_pkg::nibble_t   wr_data,
    output logic                  wr_full,
    input  udp_tx_pkg::mac_addr_t src_mac,
    input  udp_tx_pkg::mac_addr_t dest_mac,
    input  udp_tx_pkg::ip_addr_t  src_ip,
    input  udp_tx_pkg::ip_addr_t  dest_ip,
    input  udp_tx_pkg::port_t     src_port,
    input  udp_tx_pkg::port_t     dest_port,
    output logic                  tx_en,
    output udp_tx_pkg::nibble_t   tx_d,
    output logic                  mac_busy
);
    import udp_tx_pkg::*;

    // Buffer to builder and serializer
    nibble_count_t fifo_count;
    nibble_t       fifo_rd_data;
    logic          fifo_rd_en;

    // Descriptor between builder and serializer
    frame_desc_if desc_if ();

    // Payload staging
    payload_fifo i_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (wr_full),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .count   (fifo_count)
    );

    // Launch decision and header fields
    udp_header_builder i_builder (
        .clk       (clk),
        .reset     (reset),
        .count     (fifo_count),
        .flush     (flush),
        .src_mac   (src_mac),
        .dest_mac  (dest_mac),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .desc      (desc_if.builder),
        .mac_busy  (mac_busy)
    );

    // Nibble stream to the PHY
    frame_serializer i_serializer (
        .clk     (clk),
        .reset   (reset),
        .desc    (desc_if.serializer),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .tx_en   (tx_en),
        .tx_d    (tx_d)
    );

endmodule

//--- design/frame_serializer.sv
module frame_serializer (
    input  logic                clk,
    input  logic                reset,
    frame_desc_if.serializer    desc,
    output logic                rd_en,
    input  udp_tx_pkg::nibble_t rd_data,
    output logic                tx_en,
    output udp_tx_pkg::nibble_t tx_d
);
    import udp_tx_pkg::*;

    serializer_state_t state;
    // Nibbles left in the current section, minus one
    nibble_count_t     cnt;
    crc_t              crc;
    nibble_t           nibble_out;
    nibble_t           fcs_nibble;
    logic              crc_en;

    // Byte index from the top, low nibble of each byte first
    function automatic nibble_t pick_nibble(input logic [159:0] vec, input nibble_count_t idx);
        return vec[8 * (idx >> 1) + (idx[0] ? 0 : 4) +: 4];
    endfunction

    // Exchange the two nibbles of every byte
    function automatic crc_t swap_nibbles(input crc_t value);
        crc_t swapped;
        for (int b = 0; b < 4; b++) begin
            swapped[8 * b +: 4]     = value[8 * b + 4 +: 4];
            swapped[8 * b + 4 +: 4] = value[8 * b +: 4];
        end
        return swapped;
    endfunction

    // FCS goes out inverted and bit reversed
    assign fcs_nibble = ~pick_nibble(160'(swap_nibbles(crc)), cnt);

    // Nibble for the next line cycle
    always_comb begin
        rd_en      = (state == PAYLOAD);
        crc_en     = 1'b0;
        nibble_out = '0;
        case (state)
            // First preamble nibble leaves on the start strobe
            IDLE:     nibble_out = desc.start ? 4'h5 : 4'h0;
            // Last preamble nibble is the SFD
            PREAMBLE: nibble_out = (cnt == '0) ? 4'hD : 4'h5;
            MAC_HDR: begin
                nibble_out = pick_nibble(160'(desc.mac_header), cnt);
                crc_en     = 1'b1;
            end
            IP_HDR: begin
                nibble_out = pick_nibble(160'(desc.ip_header), cnt);
                crc_en     = 1'b1;
            end
            UDP_HDR: begin
                nibble_out = pick_nibble(160'(desc.udp_header), cnt);
                crc_en     = 1'b1;
            end
            PAYLOAD: begin
                nibble_out = rd_data;
                crc_en     = 1'b1;
            end
            // Zero nibbles, still part of the CRC
            PADDING:  crc_en = 1'b1;
            FCS:      nibble_out = {fcs_nibble[0], fcs_nibble[1], fcs_nibble[2], fcs_nibble[3]};
            default:  nibble_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            cnt       <= '0;
            tx_en     <= 1'b0;
            tx_d      <= '0;
            desc.done <= 1'b0;
        end else begin
            desc.done <= 1'b0;
            tx_d      <= nibble_out;
            // Line active from the start strobe until the gap
            tx_en     <= (state != GAP) && (state != IDLE || desc.start);
            if (state == IDLE) begin
                if (desc.start) begin
                    cnt   <= nibble_count_t'(PREAMBLE_SFD_NIBBLES - 2);
                    state <= PREAMBLE;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                // Section done, load the length of the next one
                case (state)
                    PREAMBLE: begin
                        cnt   <= nibble_count_t'(MAC_HEADER_NIBBLES - 1);
                        state <= MAC_HDR;
                    end
                    MAC_HDR: begin
                        cnt   <= nibble_count_t'(IP_HEADER_NIBBLES - 1);
                        state <= IP_HDR;
                    end
                    IP_HDR: begin
                        cnt   <= nibble_count_t'(UDP_HEADER_NIBBLES - 1);
                        state <= UDP_HDR;
                    end
                    UDP_HDR: begin
                        cnt   <= desc.payload_nibbles - 1'b1;
                        state <= PAYLOAD;
                    end
                    PAYLOAD: if (desc.padding_nibbles != '0) begin
                        cnt   <= desc.padding_nibbles - 1'b1;
                        state <= PADDING;
                    end else begin
                        cnt   <= nibble_count_t'(FCS_NIBBLES - 1);
                        state <= FCS;
                    end
                    PADDING: begin
                        cnt   <= nibble_count_t'(FCS_NIBBLES - 1);
                        state <= FCS;
                    end
                    // One extra count while the last FCS nibble is still out
                    FCS: begin
                        cnt   <= nibble_count_t'(GAP_NIBBLES);
                        state <= GAP;
                    end
                    default: begin
                        desc.done <= 1'b1;
                        state     <= IDLE;
                    end
                endcase
            end
        end
    end

    // Running CRC over everything after the SFD
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            crc <= '1;
        end else if (crc_en) begin
            crc <= crc_nibble_update(crc, nibble_out);
        end
    end

endmodule

//--- design/payload_fifo.sv
module payload_fifo (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_en,
    input  udp_tx_pkg::nibble_t       wr_data,
    output logic                      full,
    input  logic                      rd_en,
    output udp_tx_pkg::nibble_t       rd_data,
    output udp_tx_pkg::nibble_count_t count
);
    import udp_tx_pkg::*;

    nibble_t mem [FIFO_DEPTH_NIBBLES];

    // Pointers wrap naturally at the depth
    logic [$clog2(FIFO_DEPTH_NIBBLES)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH_NIBBLES)-1:0] rd_ptr;
    logic                                  do_wr;
    logic                                  do_rd;

    assign full  = (count == nibble_count_t'(FIFO_DEPTH_NIBBLES));
    // Writes into a full buffer are lost
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && (count != '0);

    // First word falls through, head always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the fill unchanged
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/udp_header_builder.sv
module udp_header_builder (
    input  logic                      clk,
    input  logic                      reset,
    input  udp_tx_pkg::nibble_count_t count,
    input  logic                      flush,
    input  udp_tx_pkg::mac_addr_t     src_mac,
    input  udp_tx_pkg::mac_addr_t     dest_mac,
    input  udp_tx_pkg::ip_addr_t      src_ip,
    input  udp_tx_pkg::ip_addr_t      dest_ip,
    input  udp_tx_pkg::port_t         src_port,
    input  udp_tx_pkg::port_t         dest_port,
    frame_desc_if.builder             desc,
    output logic                      mac_busy
);
    import udp_tx_pkg::*;

    // Capture, lengths, checksum sum, checksum fold, then wait for the frame
    typedef enum logic [2:0] {
        BLD_IDLE,
        BLD_LENGTHS,
        BLD_SUM,
        BLD_FOLD,
        BLD_WAIT
    } builder_state_t;

    builder_state_t state;
    logic           launch;
    nibble_count_t  capped_nibbles;
    nibble_count_t  word_nibbles;
    nibble_count_t  frame_nibbles;
    logic [19:0]    word_sum;
    logic [19:0]    sum_reg;
    logic [16:0]    fold_once;
    logic [15:0]    fold_twice;

    // Enough data for a full frame, or a flush with at least one whole word
    assign launch = (state == BLD_IDLE) &&
        ((count >= 2 * MIN_DATA_BYTES) || (flush && count >= 2 * WORD_SIZE_BYTES));

    always_comb begin
        // Cap at the maximum, then drop any partial word
        capped_nibbles = (count > nibble_count_t'(2 * MAX_DATA_BYTES)) ?
            nibble_count_t'(2 * MAX_DATA_BYTES) : count;
        word_nibbles = capped_nibbles -
            (capped_nibbles % nibble_count_t'(2 * WORD_SIZE_BYTES));
        // Frame size without padding or preamble
        frame_nibbles = nibble_count_t'(MAC_HEADER_NIBBLES + IP_HEADER_NIBBLES +
            UDP_HEADER_NIBBLES + FCS_NIBBLES) + desc.payload_nibbles;
    end

    // 16-bit word sum of the IP header, checksum field still zero here
    always_comb begin
        word_sum = '0;
        for (int k = 0; k < IP_HEADER_NIBBLES / 4; k++) begin
            word_sum = word_sum + 20'(desc.ip_header[16 * k +: 16]);
        end
    end

    // Two end-around carry folds cover any 20-bit sum
    assign fold_once  = 17'(sum_reg[15:0]) + 17'(sum_reg[19:16]);
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

    // Sequencing and the busy level
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= BLD_IDLE;
            desc.start <= 1'b0;
            mac_busy   <= 1'b0;
        end else begin
            desc.start <= 1'b0;
            case (state)
                BLD_IDLE: if (launch) begin
                    mac_busy <= 1'b1;
                    state    <= BLD_LENGTHS;
                end
                BLD_LENGTHS: state <= BLD_SUM;
                BLD_SUM:     state <= BLD_FOLD;
                BLD_FOLD: begin
                    // Checksum lands together with the strobe
                    desc.start <= 1'b1;
                    state      <= BLD_WAIT;
                end
                default: if (desc.done) begin
                    mac_busy <= 1'b0;
                    state    <= BLD_IDLE;
                end
            endcase
        end
    end

    // Descriptor contents, built up over the four launch cycles
    always_ff @(posedge clk) begin
        case (state)
            BLD_IDLE: if (launch) begin
                desc.mac_header <= {dest_mac, src_mac, ETHER_TYPE_IPV4};
                // Version 4, IHL in 32-bit words, no fragmentation
                desc.ip_header <= {4'd4, 4'(IP_HEADER_NIBBLES / 8), 8'h00,
                    16'h0000, 16'h0000, 16'h0000, IP_TTL, IP_PROTOCOL_UDP,
                    16'h0000, src_ip, dest_ip};
                // UDP checksum unused, left at zero
                desc.udp_header      <= {src_port, dest_port, 16'h0000, 16'h0000};
                desc.payload_nibbles <= word_nibbles;
            end
            BLD_LENGTHS: begin
                // IP total length covers IP header, UDP header and payload
                desc.ip_header[143:128] <=
                    16'((IP_HEADER_NIBBLES + UDP_HEADER_NIBBLES) / 2) +
                    16'(desc.payload_nibbles >> 1);
                desc.udp_header[31:16] <= 16'(UDP_HEADER_NIBBLES / 2) +
                    16'(desc.payload_nibbles >> 1);
                // Zero padding up to the minimum frame
                desc.padding_nibbles <= (frame_nibbles < nibble_count_t'(MIN_FRAME_NIBBLES)) ?
                    nibble_count_t'(MIN_FRAME_NIBBLES) - frame_nibbles : '0;
            end
            BLD_SUM:  sum_reg <= word_sum;
            BLD_FOLD: desc.ip_header[79:64] <= ~fold_twice;
            default: ;
        endcase
    end

endmodule

//--- design/frame_desc_if.sv
interface frame_desc_if;
    import udp_tx_pkg::*;

    // Launch strobe, one cycle, builder to serializer
    logic          start;
    // End of gap strobe, serializer to builder
    logic          done;

    // Frame contents, held from start until done
    mac_header_t   mac_header;
    ip_header_t    ip_header;
    udp_header_t   udp_header;
    nibble_count_t payload_nibbles;
    nibble_count_t padding_nibbles;

    modport builder (
        output start,
        output mac_header,
        output ip_header,
        output udp_header,
        output payload_nibbles,
        output padding_nibbles,
        input  done
    );

    modport serializer (
        input  start,
        input  mac_header,
        input  ip_header,
        input  udp_header,
        input  payload_nibbles,
        input  padding_nibbles,
        output done
    );

endinterface

//--- design/udp_tx_pkg.sv
package udp_tx_pkg;

    // Widths with a protocol meaning
    typedef logic [3:0]   nibble_t;
    typedef logic [47:0]  mac_addr_t;
    typedef logic [31:0]  ip_addr_t;
    typedef logic [15:0]  port_t;
    typedef logic [11:0]  nibble_count_t;
    typedef logic [31:0]  crc_t;

    // Ethernet header: destination, source, ether type
    typedef logic [111:0] mac_header_t;

    // IPv4 header in RFC 791 field order, version at the top
    typedef logic [159:0] ip_header_t;

    // UDP header: source port, destination port, length, checksum
    typedef logic [63:0]  udp_header_t;

    // Payload sizing
    localparam int unsigned WORD_SIZE_BYTES    = 4;
    localparam int unsigned MIN_DATA_BYTES     = 32;
    localparam int unsigned MAX_DATA_BYTES     = 64;
    localparam int unsigned FIFO_DEPTH_NIBBLES = 256;

    // Frame sections in nibbles
    localparam int unsigned PREAMBLE_SFD_NIBBLES = 16;
    localparam int unsigned MAC_HEADER_NIBBLES   = 28;
    localparam int unsigned IP_HEADER_NIBBLES    = 40;
    localparam int unsigned UDP_HEADER_NIBBLES   = 16;
    localparam int unsigned FCS_NIBBLES          = 8;

    // Smallest legal frame, headers through FCS, preamble excluded
    localparam int unsigned MIN_FRAME_NIBBLES = 128;

    // Interframe gap, 12 bytes of idle line
    localparam int unsigned GAP_NIBBLES = 24;

    // Fixed protocol fields
    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_TTL          = 8'hFF;
    localparam logic [7:0]  IP_PROTOCOL_UDP = 8'h11;

    // IEEE 802.3 CRC-32 generator
    localparam crc_t CRC_POLYNOMIAL = 32'h04C11DB7;

    // Transmit sequence of the serializer
    typedef enum {
        IDLE,
        PREAMBLE,
        MAC_HDR,
        IP_HDR,
        UDP_HDR,
        PAYLOAD,
        PADDING,
        FCS,
        GAP
    } serializer_state_t;

    // One nibble step of the CRC-32
    // Bits enter LSB first, as they go out on the line
    function automatic crc_t crc_nibble_update(input crc_t crc, input nibble_t data);
        crc_t next_crc;
        next_crc = crc;
        for (int j = 0; j < 4; j++) begin
            // Feedback only when the data bit differs from the CRC MSB
            next_crc = {next_crc[30:0], 1'b0} ^
                ((data[j] == next_crc[31]) ? '0 : CRC_POLYNOMIAL);
        end
        return next_crc;
    endfunction

endpackage
